// File: hdl/harnessPkg.sv
//------------------------------
// Harness package
// Widths, opcodes, reply codes and channel structs
//------------------------------
package harnessPkg;

	//------------------------------
	// Sizes and timing
	//------------------------------

	// Entries in the loopback buffer
	localparam int FifoDepth = 16;
	// Clock cycles per serial bit
	localparam int ClocksPerBit = 16;
	// Bytes in one data word
	localparam int WordBytes = 8;

	//------------------------------
	// Vector types
	//------------------------------

	// One serial byte
	typedef logic [7:0] uartByte_t;
	// One ORAM data word
	typedef logic [63:0] oramData_t;
	// Fill level, 0 up to FifoDepth inclusive
	typedef logic [$clog2(FifoDepth):0] fifoCount_t;
	// Buffer slot index
	typedef logic [$clog2(FifoDepth)-1:0] fifoPtr_t;
	// Cycle counter within one serial bit
	typedef logic [$clog2(ClocksPerBit)-1:0] bitTimer_t;

	//------------------------------
	// Frame codes
	//------------------------------

	// Host opcodes
	localparam uartByte_t OpWrite = 8'h01;
	localparam uartByte_t OpRead = 8'h02;

	// Status bytes sent back to the host
	localparam uartByte_t ReplyOk = 8'hA5;
	localparam uartByte_t ReplyFull = 8'hEF;
	localparam uartByte_t ReplyEmpty = 8'hEE;

	//------------------------------
	// Channel structs
	//------------------------------

	// Command toward the memory side
	typedef struct packed {
		logic isWrite;
		oramData_t data;
	} oramCmd_t;

	// Reply from the memory side
	typedef struct packed {
		logic ok;
		oramData_t data;
	} oramReturn_t;

	// Sticky error flags
	typedef struct packed {
		logic receiveOverflow;
		logic receivePattern;
	} harnessErrors_t;

endpackage

// File: hdl/uartRx.sv
//------------------------------
// UART receiver
// Mid-bit sampling, one byte holding register
//------------------------------
module uartRx (
	input logic Clock,
	input logic arstN,
	input logic uartRxd,
	output harnessPkg::uartByte_t rxByte,
	output logic rxValid,
	input logic rxReady,
	output logic overrun
);
	import harnessPkg::*;

	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_t;

	rxState_t state;
	logic rxMeta;
	logic rxSync;
	bitTimer_t timer;
	logic [2:0] bitIndex;
	uartByte_t shifter;
	logic bitDone;
	logic halfDone;

	// Two flop synchronizer, line idles high
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end else begin
			rxMeta <= uartRxd;
			rxSync <= rxMeta;
		end
	end

	// Full bit and half bit points
	assign bitDone = (timer == bitTimer_t'(ClocksPerBit - 1));
	assign halfDone = (timer == bitTimer_t'(ClocksPerBit / 2 - 1));

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= rxIdle;
			timer <= '0;
			bitIndex <= '0;
			rxValid <= 1'b0;
			overrun <= 1'b0;
		end else begin
			overrun <= 1'b0;
			timer <= timer + 1'b1;
			// Host side takes the held byte
			if (rxValid && rxReady)
				rxValid <= 1'b0;
			case (state)
				rxIdle: begin
					timer <= '0;
					// Falling edge opens a frame
					if (!rxSync)
						state <= rxStart;
				end
				rxStart: if (halfDone) begin
					timer <= '0;
					bitIndex <= '0;
					// Glitch if the line is high again
					state <= rxSync ? rxIdle : rxData;
				end
				rxData: if (bitDone) begin
					timer <= '0;
					bitIndex <= bitIndex + 1'b1;
					if (bitIndex == 3'd7)
						state <= rxStop;
				end
				rxStop: if (bitDone) begin
					state <= rxIdle;
					// Bad stop bit drops the byte
					if (rxSync) begin
						rxValid <= 1'b1;
						overrun <= rxValid && !rxReady;
					end
				end
				default: state <= rxIdle;
			endcase
		end
	end

	// Data path, LSB first
	always_ff @(posedge Clock) begin
		if (state == rxData && bitDone)
			shifter <= {rxSync, shifter[7:1]};
		if (state == rxStop && bitDone && rxSync)
			rxByte <= shifter;
	end

	// Overwrite only replaces a byte that was already pending
	assert property (@(posedge Clock) disable iff (!arstN)
		overrun |-> rxValid && $past(rxValid));

endmodule

// File: hdl/uartTx.sv
//------------------------------
// UART transmitter
// 8N1 frames from a valid/ready byte channel
//------------------------------
module uartTx (
	input logic Clock,
	input logic arstN,
	input harnessPkg::uartByte_t txByte,
	input logic txValid,
	output logic txReady,
	output logic uartTxd
);
	import harnessPkg::*;

	typedef enum logic {txIdle, txSend} txState_t;

	txState_t state;
	bitTimer_t timer;
	// 0 is start, 1 to 8 data, 9 stop
	logic [3:0] bitCount;
	// Data bits then the stop bit
	logic [8:0] shifter;
	logic bitDone;

	assign txReady = (state == txIdle);
	assign bitDone = (timer == bitTimer_t'(ClocksPerBit - 1));

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= txIdle;
			timer <= '0;
			bitCount <= '0;
			uartTxd <= 1'b1;
		end else begin
			case (state)
				txIdle: if (txValid) begin
					// Start bit goes out right away
					state <= txSend;
					timer <= '0;
					bitCount <= '0;
					uartTxd <= 1'b0;
				end
				txSend: begin
					timer <= timer + 1'b1;
					if (bitDone) begin
						timer <= '0;
						if (bitCount == 4'd9) begin
							// Stop bit finished
							state <= txIdle;
						end else begin
							bitCount <= bitCount + 1'b1;
							uartTxd <= shifter[0];
						end
					end
				end
				default: state <= txIdle;
			endcase
		end
	end

	// Shift register, refilled with ones
	always_ff @(posedge Clock) begin
		if (txValid && txReady)
			shifter <= {1'b1, txByte};
		else if (state == txSend && bitDone)
			shifter <= {1'b1, shifter[8:1]};
	end

	// Busy for the whole 10 bit frame, then ready again
	assert property (@(posedge Clock) disable iff (!arstN)
		(txValid && txReady) |=> (!txReady) [*10 * ClocksPerBit] ##1 txReady);

endmodule

// File: hdl/loopbackFifo.sv
//------------------------------
// Loopback buffer
// Stores written words, returns them in FIFO order
//------------------------------
module loopbackFifo (
	input logic Clock,
	input logic arstN,
	input harnessPkg::oramCmd_t cmd,
	input logic cmdValid,
	output logic cmdReady,
	output harnessPkg::oramReturn_t ret,
	output logic retValid,
	input logic retReady,
	output harnessPkg::fifoCount_t fillLevel
);
	import harnessPkg::*;

	oramData_t mem [FifoDepth];
	fifoPtr_t wrPtr;
	fifoPtr_t rdPtr;
	fifoCount_t count;
	logic cmdTake;
	logic isFull;
	logic isEmpty;
	logic doPush;
	logic doPop;

	// One command in flight at a time
	assign cmdReady = !retValid;
	assign cmdTake = cmdValid && cmdReady;

	assign isFull = (count == fifoCount_t'(FifoDepth));
	assign isEmpty = (count == '0);
	// Write drops the word when full
	assign doPush = cmdTake && cmd.isWrite && !isFull;
	// Read on empty pops nothing
	assign doPop = cmdTake && !cmd.isWrite && !isEmpty;

	assign fillLevel = count;

	//------------------------------
	// Pointers and reply handshake
	//------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			retValid <= 1'b0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
				count <= count + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
				count <= count - 1'b1;
			end
			// Reply always follows one cycle after acceptance
			if (cmdTake)
				retValid <= 1'b1;
			else if (retValid && retReady)
				retValid <= 1'b0;
		end
	end

	//------------------------------
	// Storage and reply payload
	//------------------------------
	always_ff @(posedge Clock) begin
		if (doPush)
			mem[wrPtr] <= cmd.data;
		if (cmdTake) begin
			ret.ok <= doPush || doPop;
			// Writes echo their data back
			ret.data <= cmd.isWrite ? cmd.data : mem[rdPtr];
		end
	end

	assert property (@(posedge Clock) disable iff (!arstN)
		fillLevel <= fifoCount_t'(FifoDepth));

endmodule

// File: hdl/harnessCtrl.sv
//------------------------------
// Harness controller
// Decodes host frames, issues commands, sends replies
//------------------------------
module harnessCtrl (
	input logic Clock,
	input logic arstN,
	input harnessPkg::uartByte_t rxByte,
	input logic rxValid,
	output logic rxReady,
	input logic overrun,
	output harnessPkg::uartByte_t txByte,
	output logic txValid,
	input logic txReady,
	output harnessPkg::oramCmd_t cmd,
	output logic cmdValid,
	input logic cmdReady,
	input harnessPkg::oramReturn_t ret,
	input logic retValid,
	output logic retReady,
	output harnessPkg::harnessErrors_t errors
);
	import harnessPkg::*;

	typedef enum logic [2:0] {
		idle,
		collect,
		issue,
		await,
		sendStatus,
		sendData
	} ctrlState_t;

	typedef logic [$clog2(WordBytes)-1:0] byteIndex_t;

	ctrlState_t state;
	// Gathered write data, later the read data
	oramData_t word;
	uartByte_t status;
	logic isWrite;
	// Read hit, data bytes follow the status
	logic sendWord;
	byteIndex_t byteIndex;
	logic lastByte;
	logic rxTake;
	logic txTake;
	logic badOpcode;

	//------------------------------
	// Handshake outputs
	//------------------------------

	// Bytes are only taken while decoding a frame
	assign rxReady = (state == idle) || (state == collect);
	assign rxTake = rxValid && rxReady;

	assign cmdValid = (state == issue);
	assign cmd.isWrite = isWrite;
	assign cmd.data = word;

	assign retReady = (state == await);

	assign txValid = (state == sendStatus) || (state == sendData);
	assign txByte = (state == sendData) ? word[7:0] : status;
	assign txTake = txValid && txReady;

	assign lastByte = (byteIndex == byteIndex_t'(WordBytes - 1));
	assign badOpcode = (state == idle) && rxTake
		&& (rxByte != OpWrite) && (rxByte != OpRead);

	//------------------------------
	// Frame FSM
	//------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			byteIndex <= '0;
		end else begin
			case (state)
				idle: if (rxTake) begin
					byteIndex <= '0;
					if (rxByte == OpWrite)
						state <= collect;
					else if (rxByte == OpRead)
						state <= issue;
				end
				collect: if (rxTake) begin
					byteIndex <= byteIndex + 1'b1;
					if (lastByte)
						state <= issue;
				end
				issue: if (cmdReady)
					state <= await;
				await: if (retValid)
					state <= sendStatus;
				sendStatus: if (txTake) begin
					byteIndex <= '0;
					state <= sendWord ? sendData : idle;
				end
				sendData: if (txTake) begin
					byteIndex <= byteIndex + 1'b1;
					if (lastByte)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	//------------------------------
	// Word, opcode and status
	//------------------------------
	always_ff @(posedge Clock) begin
		// Opcode latched at the frame start
		if (state == idle && rxTake)
			isWrite <= (rxByte == OpWrite);
		// LSB first, so shift in from the top
		if (state == collect && rxTake)
			word <= {rxByte, word[63:8]};
		if (state == await && retValid) begin
			word <= ret.data;
			sendWord <= ret.ok && !isWrite;
			if (ret.ok)
				status <= ReplyOk;
			else
				status <= isWrite ? ReplyFull : ReplyEmpty;
		end
		// Next data byte into the low lane
		if (state == sendData && txTake)
			word <= {8'h00, word[63:8]};
	end

	//------------------------------
	// Sticky error flags
	//------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			errors <= '0;
		end else begin
			if (overrun)
				errors.receiveOverflow <= 1'b1;
			if (badOpcode)
				errors.receivePattern <= 1'b1;
		end
	end

	// Issue and wait phases never overlap
	assert property (@(posedge Clock) disable iff (!arstN)
		!(cmdValid && retReady));

endmodule

// File: hdl/harnessTop.sv
//------------------------------
// Harness top level
// UART pins, controller, loopback buffer and LEDs
//------------------------------
module harnessTop (
	input logic Clock,
	input logic arstN,
	input logic uartRxd,
	output logic uartTxd,
	output logic [7:0] led
);
	import harnessPkg::*;

	// Serial side
	uartByte_t rxByte;
	logic rxValid;
	logic rxReady;
	logic overrun;
	uartByte_t txByte;
	logic txValid;
	logic txReady;

	// Memory side
	oramCmd_t cmd;
	logic cmdValid;
	logic cmdReady;
	oramReturn_t ret;
	logic retValid;
	logic retReady;

	// Status
	fifoCount_t fillLevel;
	harnessErrors_t errors;

	//------------------------------
	// UART
	//------------------------------
	uartRx rx_i (
		.Clock(Clock),
		.arstN(arstN),
		.uartRxd(uartRxd),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.rxReady(rxReady),
		.overrun(overrun)
	);

	uartTx tx_i (
		.Clock(Clock),
		.arstN(arstN),
		.txByte(txByte),
		.txValid(txValid),
		.txReady(txReady),
		.uartTxd(uartTxd)
	);

	//------------------------------
	// Controller and loopback
	//------------------------------
	harnessCtrl ctrl_i (
		.Clock(Clock),
		.arstN(arstN),
		.rxByte(rxByte),
		.rxValid(rxValid),
		.rxReady(rxReady),
		.overrun(overrun),
		.txByte(txByte),
		.txValid(txValid),
		.txReady(txReady),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.ret(ret),
		.retValid(retValid),
		.retReady(retReady),
		.errors(errors)
	);

	loopbackFifo fifo_i (
		.Clock(Clock),
		.arstN(arstN),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.ret(ret),
		.retValid(retValid),
		.retReady(retReady),
		.fillLevel(fillLevel)
	);

	// LEDs
	assign led[0] = errors.receiveOverflow;
	assign led[1] = errors.receivePattern;
	assign led[6:2] = fillLevel;
	// Lit while a frame is on the wire
	assign led[7] = !txReady;

endmodule

// File: tests/harnessTbUtil.svh
//------------------------------
// Testbench helpers
// LFSR stimulus and host side UART tasks
//------------------------------
`ifndef HARNESS_TB_UTIL_SVH
`define HARNESS_TB_UTIL_SVH

// Galois LFSR, taps 32, 22, 2 and 1
// One step per bit taken, newest bit lands in the LSB
function automatic logic [63:0] takeBits(input int count);
	logic [63:0] value;
	logic outBit;
	value = '0;
	for (int i = 0; i < count; i++) begin
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 32'h8020_0003;
		value = {value[62:0], outBit};
	end
	return value;
endfunction

// Random byte that is neither opcode
function automatic uartByte_t invalidOpcode();
	uartByte_t value;
	value = uartByte_t'(takeBits(8));
	while (value == OpWrite || value == OpRead)
		value = uartByte_t'(takeBits(8));
	return value;
endfunction

// Host transmit, start bit, 8 data bits LSB first, stop bit
task automatic sendByte(input uartByte_t value);
	logic [9:0] bits;
	bits = {1'b1, value, 1'b0};
	@(negedge Clock);
	for (int i = 0; i < 10; i++) begin
		uartRxd = bits[i];
		repeat (ClocksPerBit) @(negedge Clock);
	end
endtask

// Host receive, samples uartTxd near the middle of each bit
task automatic receiveByte(output uartByte_t value);
	@(negedge Clock);
	// Falling edge of the start bit
	while (uartTxd !== 1'b0)
		@(negedge Clock);
	repeat (ClocksPerBit / 2) @(negedge Clock);
	assert (uartTxd === 1'b0) else
		failRun("Reply start bit did not stay low up to its middle");
	// Transmit activity LED lit during the frame
	compareValue("led[7]", 1, led[7]);
	for (int i = 0; i < 8; i++) begin
		repeat (ClocksPerBit) @(negedge Clock);
		value[i] = uartTxd;
	end
	// Middle of the stop bit
	repeat (ClocksPerBit) @(negedge Clock);
	assert (uartTxd === 1'b1) else
		failRun("Reply stop bit was low at its middle");
endtask

`endif

// File: tests/harnessTb.sv
//------------------------------
// Harness testbench
// Random host frames checked against a FIFO model
//------------------------------
module harnessTb;
	import harnessPkg::*;

	localparam int RandomFrames = 200;
	// Fixed frames and silence windows on top of the random ones
	localparam int TotalFrames = RandomFrames + 60;
	// Longest exchange, opcode plus status plus one word
	localparam int FrameBytes = 10;
	localparam int ClockPeriod = 20;
	// 20 bit times per byte, plus a margin of 100 bit times
	localparam longint TimeoutUnits = longint'(TotalFrames) * 20 * FrameBytes
		* ClocksPerBit * ClockPeriod + 100 * ClocksPerBit * ClockPeriod;

	logic Clock;
	logic arstN;
	logic uartRxd;
	logic uartTxd;
	logic [7:0] led;

	// Stimulus generator state
	logic [31:0] lfsrState = 32'h6395_e661;
	// Reference model of the loopback buffer
	oramData_t model[$];
	// Bytes of the current exchange
	uartByte_t hostFrame[$];
	uartByte_t expectReply[$];

	harnessTop dut_i (
		.Clock(Clock),
		.arstN(arstN),
		.uartRxd(uartRxd),
		.uartTxd(uartTxd),
		.led(led)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	//------------------------------
	// Failure reporting
	//------------------------------
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "Testbench stopped at the first failure");
	endtask

	task automatic compareValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else
			failRun($sformatf("mismatch at %0t: %s expected 0x%0h actual 0x%0h",
				$time, name, expected, actual));
	endtask

	`include "harnessTbUtil.svh"

	//------------------------------
	// Frame exchange and model
	//------------------------------

	// Line must stay idle for the whole window
	task automatic expectSilence(input int bitTimes);
		repeat (bitTimes * ClocksPerBit) begin
			@(negedge Clock);
			compareValue("uartTxd", 1, uartTxd);
		end
	endtask

	// Frame goes out while the reply is collected
	task automatic exchangeFrame();
		uartByte_t got;
		fork
			begin
				foreach (hostFrame[i])
					sendByte(hostFrame[i]);
			end
			begin
				foreach (expectReply[i]) begin
					receiveByte(got);
					compareValue($sformatf("uartTxd byte %0d", i), expectReply[i], got);
				end
			end
		join
		compareValue("led[6:2]", model.size(), led[6:2]);
	endtask

	task automatic writeWord(input oramData_t data);
		hostFrame.delete();
		expectReply.delete();
		hostFrame.push_back(OpWrite);
		for (int i = 0; i < WordBytes; i++)
			hostFrame.push_back(data[8 * i +: 8]);
		// Full buffer drops the word
		if (model.size() < FifoDepth) begin
			model.push_back(data);
			expectReply.push_back(ReplyOk);
		end else begin
			expectReply.push_back(ReplyFull);
		end
		exchangeFrame();
	endtask

	task automatic readWord(input int junkBytes);
		oramData_t word;
		hostFrame.delete();
		expectReply.delete();
		hostFrame.push_back(OpRead);
		// Junk lands while the reply is on the wire
		for (int i = 0; i < junkBytes; i++)
			hostFrame.push_back(invalidOpcode());
		if (model.size() > 0) begin
			word = model.pop_front();
			expectReply.push_back(ReplyOk);
			for (int i = 0; i < WordBytes; i++)
				expectReply.push_back(word[8 * i +: 8]);
		end else begin
			expectReply.push_back(ReplyEmpty);
		end
		exchangeFrame();
	endtask

	// Watchdog
	initial begin
		#(TimeoutUnits);
		failRun("Watchdog expired before all frames were answered");
	end

	initial begin
		Clock = 1'b0;
		arstN = 1'b0;
		uartRxd = 1'b1;
		repeat (8) @(negedge Clock);
		arstN = 1'b1;

		// Idle line and dark LEDs after reset
		repeat (4 * ClocksPerBit) begin
			@(negedge Clock);
			compareValue("uartTxd", 1, uartTxd);
			compareValue("led", 0, led);
		end

		// Fill the buffer, the seventeenth write is refused
		for (int i = 0; i <= FifoDepth; i++)
			writeWord(takeBits(64));
		// Drain in order, then one read on empty
		for (int i = 0; i <= FifoDepth; i++)
			readWord(0);
		expectSilence(30);

		// Mixed random traffic
		for (int i = 0; i < RandomFrames; i++) begin
			if (takeBits(1))
				writeWord(takeBits(64));
			else
				readWord(0);
		end

		// Unknown opcode gets no reply but sets the pattern flag
		sendByte(invalidOpcode());
		expectSilence(30);
		compareValue("led[1]", 1, led[1]);
		compareValue("led[0]", 0, led[0]);
		readWord(0);

		// Three bytes during a data reply overrun the receiver
		writeWord(takeBits(64));
		readWord(3);
		compareValue("led[0]", 1, led[0]);
		for (int i = 0; i < 4; i++) begin
			if (takeBits(1))
				writeWord(takeBits(64));
			else
				readWord(0);
		end
		// both flags sticky
		compareValue("led[0]", 1, led[0]);
		compareValue("led[1]", 1, led[1]);

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: harnessTop.f
+incdir+tests
hdl/harnessPkg.sv
hdl/uartRx.sv
hdl/uartTx.sv
hdl/loopbackFifo.sv
hdl/harnessCtrl.sv
hdl/harnessTop.sv
tests/harnessTb.sv
